// ==== design/crc8_engine.sv ====
`timescale 1ns/10ps

module crc8_engine (
    input  logic clk,
    input  logic rst,
    crc_if.crc_side crc_bus
);
    import frame_pkg::*;

    logic [7:0] crc_q;
    logic [7:0] crc_next;

    // One byte folded into the remainder, MSB first
    function automatic logic [7:0] crc8_byte(input logic [7:0] crc, input logic [7:0] data);
        logic [7:0] c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = {c[6:0], 1'b0} ^ CRC8_POLY;
            end else begin
                c = {c[6:0], 1'b0};
            end
        end
        return c;
    endfunction

    assign crc_next = crc8_byte(crc_q, crc_bus.data_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= CRC8_INIT;
        end else if (crc_bus.clear) begin  // Clear wins over enable
            crc_q <= CRC8_INIT;
        end else if (crc_bus.enable) begin
            crc_q <= crc_next;
        end
    end

    assign crc_bus.crc = crc_q;

    // Sequencer only clears in idle and only feeds bytes while sending
    a_no_clear_with_enable: assert property (
        @(posedge clk) disable iff (rst)
        !(crc_bus.clear && crc_bus.enable)
    ) else $error("crc8_engine: clear and enable high together");

endmodule

// ==== design/crc_if.sv ====
`timescale 1ns/10ps

interface crc_if;

    logic       clear;    // Back to initial value
    logic       enable;   // Fold data_in this cycle
    logic [7:0] data_in;
    logic [7:0] crc;      // Running remainder

    modport seq_side (
        output clear,
        output enable,
        output data_in,
        input  crc
    );

    modport crc_side (
        input  clear,
        input  enable,
        input  data_in,
        output crc
    );

endinterface

// ==== design/frame_builder_top.sv ====
`timescale 1ns/10ps

module frame_builder_top (
    input  logic        clk,
    input  logic        rst,
    // Read data load
    input  logic [7:0]  resp_data,
    input  logic        resp_data_wr,
    // Frame request
    input  logic        build_start,
    input  logic [7:0]  status_code,
    input  logic [7:0]  cmd_echo,
    input  logic [31:0] addr_echo,
    // Transmit FIFO
    output logic [7:0]  tx_fifo_data,
    output logic        tx_fifo_wr_en,
    input  logic        tx_fifo_full,
    // Status
    output logic        builder_busy,
    output logic        response_complete
);

    frame_fields_if fields_bus ();
    crc_if          crc_bus ();

    // Header capture and data store
    response_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .resp_data    (resp_data),
        .resp_data_wr (resp_data_wr),
        .build_start  (build_start),
        .status_code  (status_code),
        .cmd_echo     (cmd_echo),
        .addr_echo    (addr_echo),
        .busy         (builder_busy),       // Blocks loads during a frame
        .frame_done   (response_complete),  // Empties the store
        .fields       (fields_bus.buf_side)
    );

    frame_sequencer u_sequencer (
        .clk               (clk),
        .rst               (rst),
        .build_start       (build_start),
        .tx_fifo_full      (tx_fifo_full),
        .tx_fifo_data      (tx_fifo_data),
        .tx_fifo_wr_en     (tx_fifo_wr_en),
        .builder_busy      (builder_busy),
        .response_complete (response_complete),
        .fields            (fields_bus.seq_side),
        .crc_bus           (crc_bus.seq_side)
    );

    // Running CRC over STATUS through last data byte
    crc8_engine u_crc (
        .clk     (clk),
        .rst     (rst),
        .crc_bus (crc_bus.crc_side)
    );

endmodule

// ==== design/frame_fields_if.sv ====
`timescale 1ns/10ps

interface frame_fields_if;
    import frame_pkg::*;

    logic [7:0]            status;      // Latched status code
    logic [7:0]            cmd;         // Latched command echo
    logic [31:0]           addr;        // Latched address echo
    logic [DATA_CNT_W-1:0] data_count;  // Bytes held in the store
    logic [DATA_IDX_W-1:0] rd_idx;      // Read index from the sequencer
    logic [7:0]            rd_byte;     // Store contents at rd_idx, no latency

    modport buf_side (
        output status,
        output cmd,
        output addr,
        output data_count,
        output rd_byte,
        input  rd_idx
    );

    modport seq_side (
        input  status,
        input  cmd,
        input  addr,
        input  data_count,
        input  rd_byte,
        output rd_idx
    );

endinterface

// ==== design/frame_pkg.sv ====
package frame_pkg;

    // Frame framing bytes
    localparam logic [7:0] SOF_DEV_TO_HOST = 8'h5A;  // Device to host start of frame
    localparam logic [7:0] STATUS_OK       = 8'h00;  // Only status treated as success

    // Command echo decode
    localparam int CMD_READ_BIT = 7;  // Set for read commands

    // Response data store sizing
    localparam int MAX_DATA_BYTES = 64;
    localparam int DATA_CNT_W     = $clog2(MAX_DATA_BYTES + 1);  // Holds 0..64
    localparam int DATA_IDX_W     = $clog2(MAX_DATA_BYTES);      // Indexes 0..63

    // Address echo goes out least significant byte first
    localparam int ADDR_BYTES = 4;

    // CRC-8, MSB first, not reflected, no final XOR
    localparam logic [7:0] CRC8_POLY = 8'h07;
    localparam logic [7:0] CRC8_INIT = 8'h00;

endpackage

// ==== design/frame_sequencer.sv ====
`timescale 1ns/10ps

module frame_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       build_start,
    input  logic       tx_fifo_full,
    output logic [7:0] tx_fifo_data,
    output logic       tx_fifo_wr_en,
    output logic       builder_busy,
    output logic       response_complete,
    frame_fields_if.seq_side fields,
    crc_if.seq_side          crc_bus
);
    import frame_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        SOF,
        STATUS,
        CMD,
        ADDR,
        DATA,
        CRC,
        DONE,
        GAP
    } seq_state_t;

    seq_state_t            state;
    seq_state_t            state_next;
    logic [1:0]            addr_cnt;   // Address byte being sent
    logic [DATA_IDX_W-1:0] data_idx;   // Data byte being sent
    logic [DATA_CNT_W-1:0] idx_plus1;
    logic                  send;       // State has a byte to put out
    logic                  feed_crc;   // Byte is covered by the CRC
    logic                  read_ok;    // Successful read, address and data follow
    logic                  last_addr;
    logic                  last_data;

    assign read_ok   = fields.cmd[CMD_READ_BIT] && (fields.status == STATUS_OK);
    assign last_addr = (addr_cnt == 2'(ADDR_BYTES - 1));
    assign idx_plus1 = DATA_CNT_W'(data_idx) + 1'b1;
    assign last_data = (idx_plus1 == fields.data_count);

    // Byte select per state
    always_comb begin
        tx_fifo_data = 8'h00;
        send         = 1'b0;
        feed_crc     = 1'b0;
        case (state)
            SOF: begin
                tx_fifo_data = SOF_DEV_TO_HOST;
                send         = 1'b1;
            end
            STATUS: begin
                tx_fifo_data = fields.status;
                send         = 1'b1;
                feed_crc     = 1'b1;
            end
            CMD: begin
                tx_fifo_data = fields.cmd;
                send         = 1'b1;
                feed_crc     = 1'b1;
            end
            ADDR: begin
                tx_fifo_data = fields.addr[addr_cnt*8 +: 8];  // LSB first
                send         = 1'b1;
                feed_crc     = 1'b1;
            end
            DATA: begin
                tx_fifo_data = fields.rd_byte;
                send         = 1'b1;
                feed_crc     = 1'b1;
            end
            CRC: begin
                tx_fifo_data = crc_bus.crc;  // Remainder after last covered byte
                send         = 1'b1;
            end
            default: ;
        endcase
    end

    assign tx_fifo_wr_en = send && !tx_fifo_full;  // One byte per accepted cycle

    assign crc_bus.clear   = (state == IDLE);
    assign crc_bus.enable  = tx_fifo_wr_en && feed_crc;
    assign crc_bus.data_in = tx_fifo_data;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:   if (build_start) state_next = SOF;
            SOF:    if (tx_fifo_wr_en) state_next = STATUS;
            STATUS: if (tx_fifo_wr_en) state_next = CMD;
            CMD: begin
                if (tx_fifo_wr_en) begin
                    state_next = read_ok ? ADDR : CRC;  // Writes and failed reads are short
                end
            end
            ADDR: begin
                if (tx_fifo_wr_en && last_addr) begin
                    state_next = (fields.data_count != '0) ? DATA : CRC;
                end
            end
            DATA:   if (tx_fifo_wr_en && last_data) state_next = CRC;
            CRC:    if (tx_fifo_wr_en) state_next = DONE;
            DONE:   state_next = GAP;
            GAP:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            addr_cnt <= '0;
            data_idx <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                addr_cnt <= '0;
                data_idx <= '0;
            end else begin
                // Counters move only on bytes the FIFO took
                if (state == ADDR && tx_fifo_wr_en) begin
                    addr_cnt <= addr_cnt + 1'b1;
                end
                if (state == DATA && tx_fifo_wr_en) begin
                    data_idx <= data_idx + 1'b1;
                end
            end
        end
    end

    assign fields.rd_idx      = data_idx;
    assign builder_busy       = (state != IDLE);
    assign response_complete  = (state == DONE);  // Cycle after the CRC write

    // Offered byte and state hold while the FIFO pushes back
    a_hold_when_full: assert property (
        @(posedge clk) disable iff (rst)
        (send && tx_fifo_full) |=> ($stable(state) && $stable(tx_fifo_data))
    ) else $error("frame_sequencer: pending byte changed while FIFO full");

    a_complete_single: assert property (
        @(posedge clk) disable iff (rst)
        response_complete |=> !response_complete
    ) else $error("frame_sequencer: response_complete longer than one cycle");

    // Start while busy never opens a new frame
    a_start_ignored_busy: assert property (
        @(posedge clk) disable iff (rst)
        (builder_busy && build_start && state != SOF) |=> (state != SOF)
    ) else $error("frame_sequencer: start taken while busy");

endmodule

// ==== design/response_buffer.sv ====
`timescale 1ns/10ps

module response_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  resp_data,     // Read data byte from the host side
    input  logic        resp_data_wr,  // Byte write strobe
    input  logic        build_start,   // Start pulse, header sampled with it
    input  logic [7:0]  status_code,
    input  logic [7:0]  cmd_echo,
    input  logic [31:0] addr_echo,
    input  logic        busy,          // Frame in progress
    input  logic        frame_done,    // Completion pulse, empties the store
    frame_fields_if.buf_side fields
);
    import frame_pkg::*;

    logic [7:0]            mem [MAX_DATA_BYTES];  // Byte store
    logic [DATA_CNT_W-1:0] data_count;
    logic [7:0]            status_q;
    logic [7:0]            cmd_q;
    logic [31:0]           addr_q;
    logic                  wr_ok;
    logic                  start_ok;

    // Writes only land between frames and while there is room
    assign wr_ok    = resp_data_wr && !busy && (data_count < DATA_CNT_W'(MAX_DATA_BYTES));
    assign start_ok = build_start && !busy;

    // Write pointer is the low bits of the count
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[data_count[DATA_IDX_W-1:0]] <= resp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_count <= '0;
        end else if (frame_done) begin
            data_count <= '0;  // Frame sent, next response starts empty
        end else if (wr_ok) begin
            data_count <= data_count + 1'b1;
        end
    end

    // Header fields held for the whole frame
    always_ff @(posedge clk) begin
        if (start_ok) begin
            status_q <= status_code;
            cmd_q    <= cmd_echo;
            addr_q   <= addr_echo;
        end
    end

    assign fields.status     = status_q;
    assign fields.cmd        = cmd_q;
    assign fields.addr       = addr_q;
    assign fields.data_count = data_count;
    assign fields.rd_byte    = mem[fields.rd_idx];  // Combinational read

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        data_count <= DATA_CNT_W'(MAX_DATA_BYTES)
    ) else $error("response_buffer: data count above store depth");

endmodule

// ==== dv/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// Bytes the DUT store should hold, in write order
logic [7:0] stored_bytes [$];
// Transmit bytes still to come for the frame in flight
logic [7:0] expected_bytes [$];

// Bit-serial CRC-8, one input bit per step, MSB first
function automatic logic [7:0] crc8_fold_byte(input logic [7:0] crc, input logic [7:0] data);
    logic [7:0] r;
    logic       fb;
    r = crc;
    for (int b = 7; b >= 0; b--) begin
        fb = r[7] ^ data[b];  // Feedback bit
        r  = r << 1;
        if (fb) begin
            r = r ^ CRC8_POLY;
        end
    end
    return r;
endfunction

// Store drops anything past its depth
task automatic store_data_byte(input logic [7:0] data);
    if (stored_bytes.size() < MAX_DATA_BYTES) begin
        stored_bytes.push_back(data);
    end
endtask

// Name used in error lines
function automatic string frame_kind(input logic [7:0] status, input logic [7:0] cmd);
    if (!cmd[CMD_READ_BIT]) begin
        return "write_resp";
    end
    return (status == STATUS_OK) ? "read_ok" : "read_fail";
endfunction

// Full expected frame, store emptied afterwards like the DUT
task automatic build_expected_frame(input logic [7:0] status, input logic [7:0] cmd,
                                    input logic [31:0] addr);
    logic [7:0] crc;
    logic [7:0] covered [$];
    covered.push_back(status);
    covered.push_back(cmd);
    if (cmd[CMD_READ_BIT] && status == STATUS_OK) begin
        for (int i = 0; i < ADDR_BYTES; i++) begin
            covered.push_back(addr[8*i +: 8]);  // LSB first
        end
        foreach (stored_bytes[i]) begin
            covered.push_back(stored_bytes[i]);
        end
    end
    crc = CRC8_INIT;
    expected_bytes.push_back(SOF_DEV_TO_HOST);  // Not covered by CRC
    foreach (covered[i]) begin
        crc = crc8_fold_byte(crc, covered[i]);
        expected_bytes.push_back(covered[i]);
    end
    expected_bytes.push_back(crc);
    stored_bytes.delete();
endtask

`endif

// ==== dv/tb_frame_builder.sv ====
`timescale 1ns/10ps

module tb_frame_builder;
    import frame_pkg::*;

    `include "frame_model.svh"

    localparam int NUM_FRAMES  = 200;
    localparam int CLK_PERIOD  = 8;
    localparam int TIMEOUT_NS  = NUM_FRAMES * 80 * 4 * CLK_PERIOD;  // Frames x bytes x cycles
    localparam int FRAME_LIMIT = 400;  // Cycles allowed per frame

    logic        clk;
    logic        rst;
    logic [7:0]  resp_data;
    logic        resp_data_wr;
    logic        build_start;
    logic [7:0]  status_code;
    logic [7:0]  cmd_echo;
    logic [31:0] addr_echo;
    logic [7:0]  tx_fifo_data;
    logic        tx_fifo_wr_en;
    logic        tx_fifo_full;
    logic        builder_busy;
    logic        response_complete;

    int    errors         = 0;
    int    bytes_checked  = 0;
    int    complete_count = 0;
    int    byte_pos       = 0;
    int    frame_no       = 0;
    int    kind_count [string];
    string cur_test       = "reset";
    logic  crc_written    = 1'b0;  // CRC byte went out at the last sample
    int    gap_check      = 0;     // Cycles since response_complete

    frame_builder_top dut0 (
        .clk               (clk),
        .rst               (rst),
        .resp_data         (resp_data),
        .resp_data_wr      (resp_data_wr),
        .build_start       (build_start),
        .status_code       (status_code),
        .cmd_echo          (cmd_echo),
        .addr_echo         (addr_echo),
        .tx_fifo_data      (tx_fifo_data),
        .tx_fifo_wr_en     (tx_fifo_wr_en),
        .tx_fifo_full      (tx_fifo_full),
        .builder_busy      (builder_busy),
        .response_complete (response_complete)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // FIFO sink, full on about 30 % of cycles
    task automatic drive_fifo_full();
        forever begin
            @(posedge clk);
            if (rst) begin
                tx_fifo_full <= 1'b0;
            end else begin
                tx_fifo_full <= ($urandom_range(99, 0) < 30);
            end
        end
    endtask

    // Sample on the falling edge, outputs settled by then
    always @(negedge clk) begin : tx_monitor
        logic [7:0] exp_byte;
        logic       crc_now;
        crc_now = 1'b0;
        if (!rst) begin
            if (tx_fifo_wr_en && tx_fifo_full) begin
                errors++;
                $display("FIFO written while full at %0t", $time);
            end
            if (tx_fifo_wr_en) begin
                if (expected_bytes.size() == 0) begin
                    errors++;
                    $display("Byte 0x%02h written with no frame pending at %0t",
                             tx_fifo_data, $time);
                end else begin
                    exp_byte = expected_bytes.pop_front();
                    bytes_checked++;
                    if (tx_fifo_data !== exp_byte) begin
                        errors++;
                        $display("ERROR %s frame %0d byte %0d: expected 0x%02h, actual 0x%02h",
                                 cur_test, frame_no, byte_pos, exp_byte, tx_fifo_data);
                    end
                    byte_pos++;
                    crc_now = (expected_bytes.size() == 0);  // Last byte is the CRC
                end
            end
            // Busy through the gap cycle, low one cycle later
            if (gap_check == 1) begin
                if (!builder_busy) begin
                    errors++;
                    $display("builder_busy low in the gap cycle, frame %0d", frame_no);
                end
                gap_check = 2;
            end else if (gap_check == 2) begin
                if (builder_busy) begin
                    errors++;
                    $display("builder_busy still high after the gap, frame %0d", frame_no);
                end
                gap_check = 0;
            end
            if (response_complete) begin
                complete_count++;
                gap_check = 1;
                if (!crc_written) begin
                    errors++;
                    $display("response_complete without a CRC write just before, frame %0d",
                             frame_no);
                end
            end else if (crc_written) begin
                errors++;
                $display("response_complete missing after CRC byte, frame %0d", frame_no);
            end
        end
        crc_written = crc_now;
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, simulation stopped", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        int          n_bytes;
        int          sel;
        int          cycles;
        logic        done;
        logic [7:0]  data;
        logic [7:0]  st;
        logic [7:0]  cmd;
        logic [31:0] addr;
        void'($urandom(32'hd85b));
        rst          = 1'b1;
        resp_data    = 8'h00;
        resp_data_wr = 1'b0;
        build_start  = 1'b0;
        status_code  = 8'h00;
        cmd_echo     = 8'h00;
        addr_echo    = 32'h0;
        tx_fifo_full = 1'b0;
        fork
            drive_fifo_full();  // Back-pressure runs alongside the stimulus
        join_none
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (tx_fifo_wr_en || builder_busy || response_complete) begin
            errors++;
            $display("Outputs not idle after reset");
        end
        if (dut0.crc_bus.crc !== CRC8_INIT) begin
            errors++;
            $display("ERROR reset: expected CRC 0x%02h, actual 0x%02h",
                     CRC8_INIT, dut0.crc_bus.crc);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // Empty and overfull stores get extra weight
            sel = $urandom_range(9, 0);
            if (sel == 0) begin
                n_bytes = 0;
            end else if (sel == 1) begin
                n_bytes = $urandom_range(66, 64);
            end else begin
                n_bytes = $urandom_range(66, 0);
            end
            for (int i = 0; i < n_bytes; i++) begin
                @(posedge clk);
                data = $urandom;
                resp_data    <= data;
                resp_data_wr <= 1'b1;
                build_start  <= 1'b0;
                store_data_byte(data);
            end
            st   = ($urandom_range(1, 0) == 0) ? STATUS_OK : 8'($urandom);  // Often success
            cmd  = $urandom;
            addr = $urandom;
            @(posedge clk);
            resp_data_wr <= 1'b0;
            build_start  <= 1'b1;
            status_code  <= st;
            cmd_echo     <= cmd;
            addr_echo    <= addr;
            frame_no = f;
            byte_pos = 0;
            cur_test = frame_kind(st, cmd);
            kind_count[cur_test]++;
            build_expected_frame(st, cmd, addr);
            @(posedge clk);  // Start taken here
            build_start <= 1'b0;

            // Starts and writes while busy must be ignored
            done   = 1'b0;
            cycles = 0;
            while (!done && cycles < FRAME_LIMIT) begin
                @(negedge clk);
                if (!builder_busy) begin
                    errors++;
                    $display("builder_busy low during frame %0d", f);
                end
                done = response_complete;
                @(posedge clk);
                resp_data_wr <= ($urandom_range(9, 0) == 0);
                resp_data    <= $urandom;
                build_start  <= ($urandom_range(19, 0) == 0);
                status_code  <= $urandom;
                cmd_echo     <= $urandom;
                addr_echo    <= $urandom;
                cycles++;
            end
            if (!done) begin
                errors++;
                $display("Frame %0d did not complete within %0d cycles", f, FRAME_LIMIT);
            end
        end

        @(posedge clk);  // Quiet inputs, DUT back in idle
        resp_data_wr <= 1'b0;
        build_start  <= 1'b0;
        repeat (6) @(posedge clk);
        if (expected_bytes.size() != 0) begin
            errors++;
            $display("%0d expected bytes never written", expected_bytes.size());
        end
        if (complete_count != NUM_FRAMES) begin
            errors++;
            $display("ERROR completion count: expected %0d, actual %0d",
                     NUM_FRAMES, complete_count);
        end

        $display("Frames %0d (write %0d, read ok %0d, read fail %0d), bytes %0d, errors %0d",
                 NUM_FRAMES, kind_count["write_resp"], kind_count["read_ok"],
                 kind_count["read_fail"], bytes_checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+dv
design/frame_pkg.sv
design/frame_fields_if.sv
design/crc_if.sv
design/crc8_engine.sv
design/response_buffer.sv
design/frame_sequencer.sv
design/frame_builder_top.sv
dv/tb_frame_builder.sv
